//--- Bender.yml
package:
  name: gp22_control

sources:
  - include_dirs:
      - include
    files:
      - design/gp22_pkg.sv
      - design/tdc_cmd_if.sv
      - design/gp22_spi_master.sv
      - design/tdc_cmd_arbiter.sv
      - design/gp22_config_seq.sv
      - design/gp22_measure_seq.sv
      - design/gp22_control.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/gp22_chip_model.sv
      - verif/tb_gp22_control.sv

//--- design/gp22_config_seq.sv
`timescale 1ns/100ps
`default_nettype none
`include "gp22_defs.svh"

module gp22_config_seq (
	input logic				i_clk_50m,
	input logic				i_rst_n,
	tdc_cmd_if.requester	bus,
	output logic			o_gp22_reset,
	output logic			o_cfg_ok,
	output logic			o_tdc_err
);
	localparam logic [3:0] S_POR = 4'd0;
	localparam logic [3:0] S_POR_OP = 4'd1;
	localparam logic [3:0] S_BOOT = 4'd2;
	localparam logic [3:0] S_TEST_WR = 4'd3;
	localparam logic [3:0] S_TEST_RD = 4'd4;
	localparam logic [3:0] S_CFG = 4'd5;
	localparam logic [3:0] S_CFG_WAIT = 4'd6;
	localparam logic [3:0] S_READY = 4'd7;
	localparam logic [3:0] S_CHECK = 4'd8;
	localparam logic [31:0] CFG1_W = `GP22_CFG1;
	localparam logic [31:0] CFG1_ALT_W = `GP22_CFG1_ALT;

	logic [3:0]				state;
	logic [31:0]			cnt;
	logic [2:0]				cfg_idx;
	logic [31:0]			cfg_word;
	logic					req_q;
	logic					is_cmd;
	logic					cmd_done;
	gp22_pkg::cmd_kind_e	cmd_kind;
	logic [7:0]				cmd_op;
	logic [31:0]			cmd_data;
	logic [7:0]				cr1_id;

	assign cmd_done = req_q && bus.ack;
	assign cr1_id = bus.rd_data.res.reg_id;	// Top byte of config 1

	always_comb begin
		case (cfg_idx)
			3'd0: cfg_word = `GP22_CFG0;
			3'd1: cfg_word = `GP22_CFG1;
			3'd2: cfg_word = `GP22_CFG2;
			3'd3: cfg_word = `GP22_CFG3;
			3'd4: cfg_word = `GP22_CFG4;
			3'd5: cfg_word = `GP22_CFG5;
			default: cfg_word = `GP22_CFG6;
		endcase
	end

	always_comb begin
		is_cmd = 1'b1;
		cmd_kind = gp22_pkg::CMD_RD;
		cmd_op = `GP22_OP_RD_CR1;
		cmd_data = 32'd0;
		case (state)
			S_POR_OP: begin
				cmd_kind = gp22_pkg::CMD_OP;
				cmd_op = `GP22_OP_POR;
			end
			S_TEST_WR: begin
				cmd_kind = gp22_pkg::CMD_WR;
				cmd_op = `GP22_OP_WR_BASE + 8'd1;
				cmd_data = {`GP22_TEST_BYTE, 24'd0};
			end
			S_CFG: begin
				cmd_kind = gp22_pkg::CMD_WR;
				cmd_op = `GP22_OP_WR_BASE + {5'd0, cfg_idx};
				cmd_data = cfg_word;
			end
			S_TEST_RD, S_CHECK: ;
			default: is_cmd = 1'b0;
		endcase
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= S_POR;
			cnt <= '0;
			cfg_idx <= '0;
			req_q <= 1'b0;
			o_gp22_reset <= 1'b1;
			o_cfg_ok <= 1'b0;
			o_tdc_err <= 1'b1;
		end else begin
			if (is_cmd && !req_q && !bus.ack)
				req_q <= 1'b1;
			else if (cmd_done)
				req_q <= 1'b0;
			case (state)
				S_POR: begin
					cnt <= cnt + 32'd1;
					if (cnt == `GP22_POR_LOW_START)
						o_gp22_reset <= 1'b0;
					if (cnt == `GP22_POR_END) begin
						o_gp22_reset <= 1'b1;
						cnt <= '0;
						state <= S_POR_OP;
					end
				end
				S_POR_OP: if (cmd_done) state <= S_BOOT;
				S_BOOT: begin
					if (cnt == `GP22_BOOT_DELAY) begin
						cnt <= '0;
						state <= S_TEST_WR;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				S_TEST_WR: if (cmd_done) state <= S_TEST_RD;
				S_TEST_RD: begin
					if (cmd_done) begin
						if (cr1_id == `GP22_TEST_BYTE) begin
							o_tdc_err <= 1'b0;
							cfg_idx <= '0;
							state <= S_CFG;
						end else begin
							state <= S_POR;	// Chip did not answer so reset again
						end
					end
				end
				S_CFG: begin
					if (cmd_done) begin
						if (cfg_idx == 3'd6)
							state <= S_CFG_WAIT;
						else
							cfg_idx <= cfg_idx + 3'd1;
					end
				end
				S_CFG_WAIT: begin
					if (cnt == `GP22_CFG_DELAY) begin
						cnt <= '0;
						o_cfg_ok <= 1'b1;
						state <= S_READY;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				S_READY: begin
					if (cnt == `GP22_CHECK_PERIOD) begin
						cnt <= '0;
						state <= S_CHECK;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				S_CHECK: begin
					if (cmd_done) begin
						// Measurement may have config 1 switched to its second value
						if (cr1_id == CFG1_W[31:24] || cr1_id == CFG1_ALT_W[31:24]) begin
							state <= S_READY;
						end else begin
							o_tdc_err <= 1'b1;
							o_cfg_ok <= 1'b0;
							state <= S_POR;
						end
					end
				end
				default: state <= S_POR;
			endcase
		end
	end

	assign bus.req = req_q;
	assign bus.kind = cmd_kind;
	assign bus.opcode = cmd_op;
	assign bus.wr_data = cmd_data;
endmodule

`default_nettype wire

//--- design/gp22_control.sv
`timescale 1ns/100ps
`default_nettype none

module gp22_control (
	input logic					i_clk_50m,
	input logic					i_rst_n,
	input logic					i_measure_en,
	input logic					i_angle_sync,
	input logic					i_gp22_intn,
	input logic					i_gp22_spi_miso,
	output logic				o_gp22_spi_mosi,
	output logic				o_gp22_spi_ssn,
	output logic				o_gp22_spi_clk,
	output logic				o_gp22_reset,
	output logic				o_tdc_err,
	output logic				o_tdc_new,
	output gp22_pkg::tdc_time_t	o_rise_data,
	output gp22_pkg::tdc_time_t	o_fall_data,
	output gp22_pkg::tdc_time_t	o_pulse_width
);
	logic cfg_ok;

	tdc_cmd_if cfg_bus ();
	tdc_cmd_if msr_bus ();
	tdc_cmd_if spi_bus ();

	gp22_config_seq u_config_seq (
		.i_clk_50m		(i_clk_50m),
		.i_rst_n		(i_rst_n),
		.bus			(cfg_bus.requester),
		.o_gp22_reset	(o_gp22_reset),
		.o_cfg_ok		(cfg_ok),
		.o_tdc_err		(o_tdc_err)
	);

	gp22_measure_seq u_measure_seq (
		.i_clk_50m		(i_clk_50m),
		.i_rst_n		(i_rst_n),
		.bus			(msr_bus.requester),
		.i_cfg_ok		(cfg_ok),
		.i_measure_en	(i_measure_en),
		.i_angle_sync	(i_angle_sync),
		.i_gp22_intn	(i_gp22_intn),
		.o_rise_data	(o_rise_data),
		.o_fall_data	(o_fall_data),
		.o_pulse_width	(o_pulse_width),
		.o_tdc_new		(o_tdc_new)
	);

	tdc_cmd_arbiter u_arbiter (
		.i_clk_50m	(i_clk_50m),
		.i_rst_n	(i_rst_n),
		.cfg_s		(cfg_bus.server),
		.msr_s		(msr_bus.server),
		.spi_m		(spi_bus.requester)
	);

	gp22_spi_master u_spi_master (
		.i_clk_50m	(i_clk_50m),
		.i_rst_n	(i_rst_n),
		.bus		(spi_bus.server),
		.i_spi_miso	(i_gp22_spi_miso),
		.o_spi_sck	(o_gp22_spi_clk),
		.o_spi_ssn	(o_gp22_spi_ssn),
		.o_spi_mosi	(o_gp22_spi_mosi)
	);
endmodule

`default_nettype wire

//--- design/gp22_measure_seq.sv
`timescale 1ns/100ps
`default_nettype none
`include "gp22_defs.svh"

module gp22_measure_seq (
	input logic					i_clk_50m,
	input logic					i_rst_n,
	tdc_cmd_if.requester		bus,
	input logic					i_cfg_ok,
	input logic					i_measure_en,
	input logic					i_angle_sync,
	input logic					i_gp22_intn,
	output gp22_pkg::tdc_time_t	o_rise_data,
	output gp22_pkg::tdc_time_t	o_fall_data,
	output gp22_pkg::tdc_time_t	o_pulse_width,
	output logic				o_tdc_new
);
	localparam logic [3:0] M_IDLE = 4'd0;
	localparam logic [3:0] M_INIT = 4'd1;
	localparam logic [3:0] M_SYNC = 4'd2;
	localparam logic [3:0] M_WAIT_INT = 4'd3;
	localparam logic [3:0] M_STAT = 4'd4;
	localparam logic [3:0] M_RES0 = 4'd5;
	localparam logic [3:0] M_CFG_ALT = 4'd6;
	localparam logic [3:0] M_RECFG = 4'd7;
	localparam logic [3:0] M_RES1 = 4'd8;
	localparam logic [3:0] M_CFG_REST = 4'd9;

	logic [3:0]				state;
	logic [31:0]			cnt;
	logic					req_q;
	logic					is_cmd;
	logic					cmd_done;
	logic					intn_q1;
	logic					intn_q2;
	logic [2:0]				hit1_cnt;
	logic [2:0]				hit2_cnt;
	gp22_pkg::tdc_time_t	rise_q;
	gp22_pkg::tdc_time_t	fall_q;
	gp22_pkg::tdc_time_t	width_q;
	logic					tdc_new_q;
	gp22_pkg::cmd_kind_e	cmd_kind;
	logic [7:0]				cmd_op;
	logic [31:0]			cmd_data;

	assign cmd_done = req_q && bus.ack;

	always_comb begin
		is_cmd = 1'b1;
		cmd_kind = gp22_pkg::CMD_RD;
		cmd_op = `GP22_OP_RD_STAT;
		cmd_data = 32'd0;
		case (state)
			M_INIT: begin
				cmd_kind = gp22_pkg::CMD_OP;
				cmd_op = `GP22_OP_INIT;
			end
			M_STAT: ;
			M_RES0: cmd_op = `GP22_OP_RD_RES0;
			M_RES1: cmd_op = `GP22_OP_RD_RES1;
			M_CFG_ALT: begin
				cmd_kind = gp22_pkg::CMD_WR;
				cmd_op = `GP22_OP_WR_BASE + 8'd1;
				cmd_data = `GP22_CFG1_ALT;
			end
			M_CFG_REST: begin
				cmd_kind = gp22_pkg::CMD_WR;
				cmd_op = `GP22_OP_WR_BASE + 8'd1;
				cmd_data = `GP22_CFG1;
			end
			default: is_cmd = 1'b0;
		endcase
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			intn_q1 <= 1'b1;
			intn_q2 <= 1'b1;
		end else begin
			intn_q1 <= i_gp22_intn;	// Async pin from the chip
			intn_q2 <= intn_q1;
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= M_IDLE;
			cnt <= '0;
			req_q <= 1'b0;
			hit1_cnt <= '0;
			hit2_cnt <= '0;
			rise_q <= '0;
			fall_q <= '0;
			tdc_new_q <= 1'b0;
		end else begin
			tdc_new_q <= 1'b0;
			if (is_cmd && !req_q && !bus.ack)
				req_q <= 1'b1;
			else if (cmd_done)
				req_q <= 1'b0;
			case (state)
				M_IDLE: if (i_cfg_ok && i_measure_en) state <= M_INIT;
				M_INIT: if (cmd_done) state <= M_SYNC;
				M_SYNC: begin
					if (i_angle_sync) begin
						cnt <= '0;
						state <= M_WAIT_INT;
					end
				end
				M_WAIT_INT: begin
					if (!intn_q2) begin
						cnt <= '0;
						state <= M_STAT;
					end else if (cnt == `GP22_HIT_TIMEOUT) begin
						rise_q <= `GP22_NO_HIT;	// No echo this cycle
						fall_q <= `GP22_NO_HIT;
						tdc_new_q <= 1'b1;
						state <= M_IDLE;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				M_STAT: begin
					if (cmd_done) begin
						hit1_cnt <= bus.rd_data.stat.hit1_cnt;
						hit2_cnt <= bus.rd_data.stat.hit2_cnt;
						state <= M_RES0;
					end
				end
				M_RES0: begin
					if (cmd_done) begin
						rise_q <= (hit1_cnt != 3'd0) ? bus.rd_data.res.time_val : '0;
						state <= M_CFG_ALT;
					end
				end
				M_CFG_ALT: if (cmd_done) state <= M_RECFG;
				M_RECFG: begin
					if (cnt == `GP22_RECFG_DELAY) begin
						cnt <= '0;
						state <= M_RES1;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				M_RES1: begin
					if (cmd_done) begin
						fall_q <= (hit2_cnt != 3'd0) ? bus.rd_data.res.time_val : '0;
						state <= M_CFG_REST;
					end
				end
				M_CFG_REST: begin
					if (cmd_done) begin
						tdc_new_q <= 1'b1;
						state <= M_IDLE;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n)
			width_q <= '0;
		else if (tdc_new_q && fall_q >= rise_q)
			width_q <= fall_q - rise_q;	// Keep old width on reversed edges
	end

	assign bus.req = req_q;
	assign bus.kind = cmd_kind;
	assign bus.opcode = cmd_op;
	assign bus.wr_data = cmd_data;
	assign o_rise_data = rise_q;
	assign o_fall_data = fall_q;
	assign o_pulse_width = width_q;
	assign o_tdc_new = tdc_new_q;
endmodule

`default_nettype wire

//--- design/gp22_pkg.sv
`default_nettype none

package gp22_pkg;
	typedef enum logic [1:0] {
		CMD_OP = 2'd0,	// Opcode byte only
		CMD_WR = 2'd1,
		CMD_RD = 2'd2
	} cmd_kind_e;

	typedef logic [15:0] tdc_time_t;

	typedef struct packed {
		logic [6:0]	rsvd_hi;
		logic [2:0]	hit2_cnt;
		logic [2:0]	hit1_cnt;
		logic [18:0]	rsvd_lo;
	} stat_view_t;

	typedef struct packed {
		logic [7:0]	reg_id;
		logic [6:0]	rsvd;
		tdc_time_t	time_val;
		logic		frac_lsb;
	} res_view_t;

	typedef union packed {
		logic [31:0]	raw;
		stat_view_t		stat;
		res_view_t		res;
	} rd_word_u;
endpackage

`default_nettype wire

//--- design/gp22_spi_master.sv
`timescale 1ns/100ps
`default_nettype none
`include "gp22_defs.svh"

module gp22_spi_master (
	input logic			i_clk_50m,
	input logic			i_rst_n,
	tdc_cmd_if.server	bus,
	input logic			i_spi_miso,
	output logic		o_spi_sck,
	output logic		o_spi_ssn,
	output logic		o_spi_mosi
);
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_SHIFT = 2'd1;
	localparam logic [1:0] ST_ACK = 2'd2;
	localparam logic [7:0] HALF_LAST = 8'(`GP22_SPI_HALF - 32'd1);

	logic [1:0]		state;
	logic [7:0]		half_cnt;
	logic [5:0]		bits_left;
	logic [39:0]	tx_sr;
	logic [31:0]	rx_sr;
	logic			sck;
	logic			ssn;
	logic			mosi;
	logic			ack_q;
	logic			sck_edge;

	assign sck_edge = (state == ST_SHIFT) && (half_cnt == HALF_LAST);

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
			half_cnt <= '0;
			bits_left <= '0;
			sck <= 1'b0;
			ssn <= 1'b1;
			mosi <= 1'b0;
			ack_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (bus.req) begin
						ssn <= 1'b0;
						half_cnt <= '0;
						bits_left <= (bus.kind == gp22_pkg::CMD_OP) ? 6'd8 : 6'd40;
						state <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					if (sck_edge) begin
						half_cnt <= '0;
						sck <= ~sck;
						if (!sck) begin
							mosi <= tx_sr[39];	// Launch on rising SCK
						end else begin
							bits_left <= bits_left - 6'd1;
							if (bits_left == 6'd1)
								state <= ST_ACK;
						end
					end else begin
						half_cnt <= half_cnt + 8'd1;
					end
				end
				ST_ACK: begin
					ssn <= 1'b1;
					ack_q <= 1'b1;
					if (ack_q && !bus.req) begin
						ack_q <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk_50m) begin
		if (state == ST_IDLE && bus.req)
			tx_sr <= {bus.opcode, (bus.kind == gp22_pkg::CMD_WR) ? bus.wr_data : 32'd0};
		else if (sck_edge && !sck)
			tx_sr <= {tx_sr[38:0], 1'b0};
		if (sck_edge && sck)
			rx_sr <= {rx_sr[30:0], i_spi_miso};	// Sample on falling SCK
	end

	assign bus.ack = ack_q;
	assign bus.rd_data = rx_sr;	// Last 32 bits of the frame
	assign o_spi_sck = sck;
	assign o_spi_ssn = ssn;
	assign o_spi_mosi = mosi;

	a_cmd_stable: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		$past(bus.req) && bus.req |-> $stable(bus.kind) && $stable(bus.opcode));
endmodule

`default_nettype wire

//--- design/tdc_cmd_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module tdc_cmd_arbiter (
	input logic				i_clk_50m,
	input logic				i_rst_n,
	tdc_cmd_if.server		cfg_s,
	tdc_cmd_if.server		msr_s,
	tdc_cmd_if.requester	spi_m
);
	logic busy;
	logic grant;	// High selects the measurement side
	logic prio;
	logic pick_msr;
	logic gnt_req;

	assign pick_msr = msr_s.req && (prio || !cfg_s.req);
	assign gnt_req = grant ? msr_s.req : cfg_s.req;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			grant <= 1'b0;
			prio <= 1'b0;
		end else if (!busy) begin
			if (cfg_s.req || msr_s.req) begin
				busy <= 1'b1;
				grant <= pick_msr;
				prio <= !pick_msr;	// Other side wins next time
			end
		end else if (!gnt_req && !spi_m.ack) begin
			busy <= 1'b0;
		end
	end

	assign spi_m.req = busy && gnt_req;
	assign spi_m.kind = grant ? msr_s.kind : cfg_s.kind;
	assign spi_m.opcode = grant ? msr_s.opcode : cfg_s.opcode;
	assign spi_m.wr_data = grant ? msr_s.wr_data : cfg_s.wr_data;

	assign cfg_s.ack = busy && !grant && spi_m.ack;
	assign msr_s.ack = busy && grant && spi_m.ack;
	assign cfg_s.rd_data = grant ? '0 : spi_m.rd_data;
	assign msr_s.rd_data = grant ? spi_m.rd_data : '0;

	a_grant_hold: assert property (@(posedge i_clk_50m) disable iff (!i_rst_n)
		(spi_m.req || spi_m.ack) |=> $stable(grant));
endmodule

`default_nettype wire

//--- design/tdc_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface tdc_cmd_if;
	logic					req;
	gp22_pkg::cmd_kind_e	kind;
	logic [7:0]				opcode;
	logic [31:0]			wr_data;	// Ignored unless kind is a write
	logic					ack;
	gp22_pkg::rd_word_u		rd_data;	// Valid while ack is high

	modport requester (
		output req, kind, opcode, wr_data,
		input ack, rd_data
	);

	modport server (
		input req, kind, opcode, wr_data,
		output ack, rd_data
	);
endinterface

`default_nettype wire

//--- include/gp22_defs.svh
`ifndef GP22_DEFS_SVH
`define GP22_DEFS_SVH

`define GP22_POR_LOW_START	32'd50
`define GP22_POR_END		32'd100
`define GP22_BOOT_DELAY		32'd400
`define GP22_CFG_DELAY		32'd40
`define GP22_RECFG_DELAY	32'd60
`define GP22_HIT_TIMEOUT	32'd174
`define GP22_CHECK_PERIOD	32'd6000
`define GP22_SPI_HALF		32'd2

`define GP22_OP_POR			8'h50
`define GP22_OP_INIT		8'h70
`define GP22_OP_WR_BASE		8'h80
`define GP22_OP_RD_STAT		8'hB4
`define GP22_OP_RD_RES0		8'hB0
`define GP22_OP_RD_RES1		8'hB1
`define GP22_OP_RD_CR1		8'hB5

`define GP22_CFG0			32'h0004_2400
`define GP22_CFG1			32'h0149_0000
`define GP22_CFG2			32'hC000_0000
`define GP22_CFG3			32'h2000_0000
`define GP22_CFG4			32'h2000_0000
`define GP22_CFG5			32'h0000_0000
`define GP22_CFG6			32'h0000_0000
`define GP22_CFG1_ALT		32'h0949_0000
`define GP22_TEST_BYTE		8'hAB
`define GP22_NO_HIT			16'hFFFF

`endif

//--- sim.f
+incdir+include
design/gp22_pkg.sv
design/tdc_cmd_if.sv
design/gp22_spi_master.sv
design/tdc_cmd_arbiter.sv
design/gp22_config_seq.sv
design/gp22_measure_seq.sv
design/gp22_control.sv
verif/gp22_chip_model.sv
verif/tb_gp22_control.sv

//--- verif/gp22_chip_model.sv
`timescale 1ns/100ps
`default_nettype none
`include "gp22_defs.svh"

module gp22_chip_model (
	input logic			i_clk_50m,
	input logic			i_rst_n,
	input logic			i_spi_sck,
	input logic			i_spi_ssn,
	input logic			i_spi_mosi,
	output logic		o_spi_miso,
	output logic		o_intn,
	input logic [2:0]	i_hit1_cnt,
	input logic [2:0]	i_hit2_cnt,
	input logic [15:0]	i_res0,
	input logic [15:0]	i_res1,
	input logic [7:0]	i_int_delay,
	input logic			i_no_int,
	input logic			i_corrupt_cr1,
	output logic [6:0]	o_wr_mask
);
	logic [31:0]	regs [0:6];
	logic			sck_q;
	logic			ssn_q;
	logic [5:0]		bit_cnt;
	logic [7:0]		op;
	logic [7:0]		op_next;
	logic [31:0]	wr_sr;
	logic [31:0]	rd_sr;
	logic [7:0]		int_cnt;
	logic			int_armed;
	logic			cr1_bad;	// Sticky until the next power-on opcode

	assign op_next = {op[6:0], i_spi_mosi};

	// Read word for a read opcode, with filler in the unused bits
	function automatic logic [31:0] answer(input logic [7:0] code);
		case (code)
			`GP22_OP_RD_STAT: answer = {7'h2A, i_hit2_cnt, i_hit1_cnt, 19'h5_A5A5};
			`GP22_OP_RD_RES0: answer = {8'h5A, 7'h33, i_res0, 1'b1};
			`GP22_OP_RD_RES1: answer = {8'hA5, 7'h4C, i_res1, 1'b0};
			`GP22_OP_RD_CR1: answer = cr1_bad ? {8'h00, regs[1][23:0]} : regs[1];
			default: answer = 32'd0;
		endcase
	endfunction

	always @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < 7; i++)
				regs[i] <= 32'd0;
			sck_q <= 1'b0;
			ssn_q <= 1'b1;
			bit_cnt <= '0;
			op <= '0;
			wr_sr <= '0;
			rd_sr <= '0;
			int_cnt <= '0;
			int_armed <= 1'b0;
			cr1_bad <= 1'b0;
			o_spi_miso <= 1'b0;
			o_intn <= 1'b1;
			o_wr_mask <= '0;
		end else begin
			sck_q <= i_spi_sck;
			ssn_q <= i_spi_ssn;
			if (i_corrupt_cr1)
				cr1_bad <= 1'b1;
			if (int_armed) begin
				if (int_cnt == 8'd0) begin
					o_intn <= 1'b0;	// Measurement finished
					int_armed <= 1'b0;
				end else begin
					int_cnt <= int_cnt - 8'd1;
				end
			end
			if (ssn_q && !i_spi_ssn) begin
				bit_cnt <= '0;
			end else if (!i_spi_ssn && i_spi_sck && !sck_q) begin
				bit_cnt <= bit_cnt + 6'd1;	// MOSI is stable after a rising SCK
				if (bit_cnt < 6'd8) begin
					op <= op_next;
					if (bit_cnt == 6'd7) begin
						rd_sr <= answer(op_next);
						if (op_next == `GP22_OP_INIT) begin
							o_intn <= 1'b1;
							int_cnt <= i_int_delay;
							int_armed <= !i_no_int;
						end
						if (op_next == `GP22_OP_POR) begin
							for (int i = 0; i < 7; i++)
								regs[i] <= 32'd0;
							o_wr_mask <= '0;
							cr1_bad <= 1'b0;
						end
					end
				end else begin
					wr_sr <= {wr_sr[30:0], i_spi_mosi};
					o_spi_miso <= rd_sr[31];
					rd_sr <= {rd_sr[30:0], 1'b0};
				end
			end
			if (!ssn_q && i_spi_ssn && bit_cnt == 6'd40
					&& (op & 8'hF8) == `GP22_OP_WR_BASE && op[2:0] != 3'd7) begin
				regs[op[2:0]] <= wr_sr;
				o_wr_mask[op[2:0]] <= 1'b1;
			end
		end
	end
endmodule

`default_nettype wire

//--- verif/tb_gp22_control.sv
`timescale 1ns/100ps
`default_nettype none
`include "gp22_defs.svh"

module tb_gp22_control;
	localparam int N_RANDOM = 12;
	localparam int N_AFTER = 4;
	localparam int N_MEAS = 5 + N_RANDOM + N_AFTER;
	localparam int CMD_CYCLES = 40 * 2 * `GP22_SPI_HALF + 8;
	localparam int CFG_CYCLES = `GP22_POR_END + `GP22_BOOT_DELAY + `GP22_CFG_DELAY
		+ 10 * CMD_CYCLES;
	localparam int MEAS_CYCLES = 8 * CMD_CYCLES + `GP22_HIT_TIMEOUT + `GP22_RECFG_DELAY;
	localparam int CYCLE_LIMIT = 2 * CFG_CYCLES + N_MEAS * MEAS_CYCLES + `GP22_CHECK_PERIOD;

	logic					clk;
	logic					rst_n;
	logic					measure_en;
	logic					angle_sync;
	logic					gp22_intn;
	logic					spi_miso;
	logic					spi_mosi;
	logic					spi_ssn;
	logic					spi_clk;
	logic					gp22_reset;
	logic					tdc_err;
	logic					tdc_new;
	gp22_pkg::tdc_time_t	rise_data;
	gp22_pkg::tdc_time_t	fall_data;
	gp22_pkg::tdc_time_t	pulse_width;
	logic [2:0]				hit1_cnt;
	logic [2:0]				hit2_cnt;
	logic [15:0]			res0;
	logic [15:0]			res1;
	logic [7:0]				int_delay;
	logic					no_int;
	logic					corrupt_cr1;
	logic [6:0]				wr_mask;
	integer					seed;
	int						errors = 0;
	int						checks = 0;
	int						n_meas = 0;
	int						cycles = 0;
	logic [47:0]			exp_res;
	logic [15:0]			exp_width = 16'd0;
	logic					width_due = 1'b0;

	gp22_control DUT (
		.i_clk_50m			(clk),
		.i_rst_n			(rst_n),
		.i_measure_en		(measure_en),
		.i_angle_sync		(angle_sync),
		.i_gp22_intn		(gp22_intn),
		.i_gp22_spi_miso	(spi_miso),
		.o_gp22_spi_mosi	(spi_mosi),
		.o_gp22_spi_ssn		(spi_ssn),
		.o_gp22_spi_clk		(spi_clk),
		.o_gp22_reset		(gp22_reset),
		.o_tdc_err			(tdc_err),
		.o_tdc_new			(tdc_new),
		.o_rise_data		(rise_data),
		.o_fall_data		(fall_data),
		.o_pulse_width		(pulse_width)
	);

	gp22_chip_model u_chip (
		.i_clk_50m		(clk),
		.i_rst_n		(rst_n),
		.i_spi_sck		(spi_clk),
		.i_spi_ssn		(spi_ssn),
		.i_spi_mosi		(spi_mosi),
		.o_spi_miso		(spi_miso),
		.o_intn			(gp22_intn),
		.i_hit1_cnt		(hit1_cnt),
		.i_hit2_cnt		(hit2_cnt),
		.i_res0			(res0),
		.i_res1			(res1),
		.i_int_delay	(int_delay),
		.i_no_int		(no_int),
		.i_corrupt_cr1	(corrupt_cr1),
		.o_wr_mask		(wr_mask)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// Expected {rise, fall, width} for one measurement cycle
	function automatic logic [47:0] expected_result(
		input logic [2:0] h1,
		input logic [2:0] h2,
		input logic [15:0] t0,
		input logic [15:0] t1,
		input logic timed_out,
		input logic [15:0] prev_width
	);
		logic [15:0] rise;
		logic [15:0] fall;
		logic [15:0] width;
		if (timed_out) begin
			rise = `GP22_NO_HIT;
			fall = `GP22_NO_HIT;
		end else begin
			rise = (h1 != 3'd0) ? t0 : 16'd0;
			fall = (h2 != 3'd0) ? t1 : 16'd0;
		end
		width = (fall >= rise) ? fall - rise : prev_width;
		return {rise, fall, width};
	endfunction

	function automatic logic [31:0] cfg_value(input int idx);
		case (idx)
			0: cfg_value = `GP22_CFG0;
			1: cfg_value = `GP22_CFG1;
			2: cfg_value = `GP22_CFG2;
			3: cfg_value = `GP22_CFG3;
			4: cfg_value = `GP22_CFG4;
			5: cfg_value = `GP22_CFG5;
			default: cfg_value = `GP22_CFG6;
		endcase
	endfunction

	always @(negedge clk) begin
		if (width_due) begin
			checks++;
			if (pulse_width !== exp_width) begin
				errors++;
				$display("MISMATCH at %0t: pulse width %h, expected %h", $time, pulse_width,
					exp_width);
			end
			if (tdc_new) begin
				errors++;
				$display("Result strobe stayed high for more than one cycle at %0t", $time);
			end
			width_due = 1'b0;
		end else if (tdc_new) begin
			exp_res = expected_result(hit1_cnt, hit2_cnt, res0, res1, no_int, exp_width);
			exp_width = exp_res[15:0];
			width_due = 1'b1;
			n_meas++;
			checks++;
			if (rise_data !== exp_res[47:32] || fall_data !== exp_res[31:16]) begin
				errors++;
				$display("MISMATCH at %0t: rise %h fall %h, expected rise %h fall %h", $time,
					rise_data, fall_data, exp_res[47:32], exp_res[31:16]);
			end
		end
	end

	task automatic finish_run(input logic timed_out);
		$display("Measurements: %0d, checks: %0d, errors: %0d", n_meas, checks, errors);
		if (errors == 0 && !timed_out)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", CYCLE_LIMIT);
			finish_run(1'b1);
		end
	end

	task automatic check_reset_state();
		checks++;
		if (gp22_reset !== 1'b1 || tdc_new !== 1'b0 || tdc_err !== 1'b1
				|| spi_ssn !== 1'b1 || spi_clk !== 1'b0) begin
			errors++;
			$display("MISMATCH at %0t: outputs after reset are not at their idle values", $time);
		end
	endtask

	task automatic check_config();
		for (int i = 0; i < 7; i++) begin
			checks++;
			if (u_chip.regs[i] !== cfg_value(i)) begin
				errors++;
				$display("MISMATCH at %0t: config register %0d holds %h, expected %h", $time, i,
					u_chip.regs[i], cfg_value(i));
			end
		end
		checks++;
		if (tdc_err !== 1'b0) begin
			errors++;
			$display("MISMATCH at %0t: o_tdc_err is high after configuration", $time);
		end
	endtask

	// Program the chip model and wait for the next published result
	task automatic run_measure(
		input logic [2:0] h1,
		input logic [2:0] h2,
		input logic [15:0] t0,
		input logic [15:0] t1,
		input logic [7:0] dly,
		input logic silent
	);
		int start;
		hit1_cnt = h1;
		hit2_cnt = h2;
		res0 = t0;
		res1 = t1;
		int_delay = dly;
		no_int = silent;
		start = n_meas;
		wait (n_meas > start);
		@(negedge clk);
	endtask

	task automatic run_random(input int count);
		logic [31:0] r_hit;
		logic [31:0] r_time;
		for (int k = 0; k < count; k++) begin
			r_hit = $random(seed);
			r_time = $random(seed);
			run_measure(r_hit[2:0], r_hit[5:3], r_time[15:0], r_time[31:16],
				8'd8 + {1'b0, r_hit[12:6]}, r_hit[15:13] == 3'd0);
		end
	endtask

	initial begin
		seed = 32'hcb54_104a;
		rst_n = 1'b0;
		measure_en = 1'b0;
		angle_sync = 1'b0;
		hit1_cnt = 3'd1;
		hit2_cnt = 3'd1;
		res0 = 16'd0;
		res1 = 16'd0;
		int_delay = 8'd20;
		no_int = 1'b0;
		corrupt_cr1 = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_reset_state();

		wait (tdc_err == 1'b0);
		wait (wr_mask == 7'h7f);
		@(negedge clk);
		check_config();

		measure_en = 1'b1;
		angle_sync = 1'b1;
		run_measure(3'd3, 3'd2, 16'd100, 16'd900, 8'd30, 1'b0);
		run_measure(3'd1, 3'd1, 16'd5000, 16'd1200, 8'd60, 1'b0);	// Reversed edges
		run_measure(3'd0, 3'd4, 16'd300, 16'd700, 8'd20, 1'b0);
		run_measure(3'd2, 3'd0, 16'd400, 16'd50, 8'd40, 1'b0);
		run_measure(3'd1, 3'd1, 16'd10, 16'd20, 8'd0, 1'b1);	// No interrupt
		run_random(N_RANDOM);

		// Sticky CR1 fault caught by the next health check
		corrupt_cr1 = 1'b1;
		@(negedge clk);
		corrupt_cr1 = 1'b0;
		wait (tdc_err == 1'b1);
		wait (tdc_err == 1'b0);
		wait (wr_mask == 7'h7f);
		@(negedge clk);
		check_config();
		run_random(N_AFTER);

		finish_run(1'b0);
	end
endmodule

`default_nettype wire
